// File: common/icache_fetch_pkg.sv
// Widths, queue depths and sequencer state codes for the instruction fetch front end
// The widths are fixed and shared by the RTL and the testbench

package icache_fetch_pkg;

    ////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////

    // Instruction address width, both to the cache and to memory
    localparam int unsigned ADDR_W = 32;
    // Read ID width, also the reboot detection width
    localparam int unsigned ID_W = 8;
    // Instruction width, fixed whatever the core architecture
    localparam int unsigned ILEN = 32;

    ////////////////////////////////////////
    // Queue depths
    ////////////////////////////////////////

    // Outstanding requests from the core controller
    localparam int unsigned REQ_DEPTH = 4;
    // Missed entries waiting for a refill
    localparam int unsigned MISS_DEPTH = 8;

    ////////////////////////////////////////
    // Sequencer states
    ////////////////////////////////////////

    localparam int unsigned SEQ_W = 2;
    // Waiting for work
    localparam logic [SEQ_W-1:0] SEQ_IDLE = 2'd0;
    // Reading request queue entries
    localparam logic [SEQ_W-1:0] SEQ_SERVE = 2'd1;
    // Memory read issued, waiting for the line write
    localparam logic [SEQ_W-1:0] SEQ_LOAD = 2'd2;
    // Re-reading missed entries after a refill
    localparam logic [SEQ_W-1:0] SEQ_MISSED = 2'd3;

endpackage

// File: common/fetch_queue_if.sv
// One queue's push, head, status, pull and clear signals
// Widths come from the shared package, no parameters

interface fetch_queue_if import icache_fetch_pkg::*; ();

    // Push side
    logic              push;
    logic [ADDR_W-1:0] push_addr;
    logic [ID_W-1:0]   push_id;
    logic              full;

    // Head of the queue, valid while empty is low
    logic [ADDR_W-1:0] head_addr;
    logic [ID_W-1:0]   head_id;
    logic              empty;

    // Pull removes the head, clear drops everything
    logic              pull;
    logic              clear;

    // The queue itself
    modport queue (
        input  push, push_addr, push_id, pull, clear,
        output full, head_addr, head_id, empty
    );

    // Consumer only, push comes from elsewhere
    modport drain (
        input  head_addr, head_id, empty, full,
        output pull, clear
    );

    // Consumer that also refills the queue
    modport fill_drain (
        input  head_addr, head_id, empty, full,
        output push, push_addr, push_id, pull, clear
    );

endinterface

// File: fetcher/fetch_queue.sv
// Circular queue of address and ID entries with a one-cycle clear
// Head is shown combinationally; push while full and pull while empty are ignored

module fetch_queue import icache_fetch_pkg::*; #(
    parameter int unsigned depth = 4
) (
    input logic          aclk,
    input logic          aresetn,
    fetch_queue_if.queue q
);

    // Pointer and fill count widths, depth need not be a power of two
    localparam int unsigned PTR_W = (depth > 1) ? $clog2(depth) : 1;
    localparam int unsigned CNT_W = $clog2(depth + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(depth - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(depth);

    ////////////////////////////////////////
    // Storage and pointers
    ////////////////////////////////////////

    logic [ADDR_W-1:0] addr_mem [depth];
    logic [ID_W-1:0]   id_mem [depth];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;

    // Accepted operations, clear overrides both
    logic push_ok;
    logic pull_ok;

    assign push_ok = q.push & ~q.full & ~q.clear;
    assign pull_ok = q.pull & ~q.empty & ~q.clear;

    // Status from the fill count
    assign q.full  = (count == FULL_CNT);
    assign q.empty = (count == '0);

    // Head entry, no output register
    assign q.head_addr = addr_mem[rd_ptr];
    assign q.head_id   = id_mem[rd_ptr];

    ////////////////////////////////////////
    // Control state
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (q.clear) begin
            // Jump in the fetch stream, drop every entry at once
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pull_ok) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pull keep the count
            if (push_ok && !pull_ok) begin
                count <= count + 1'b1;
            end else if (pull_ok && !push_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Entry storage
    ////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (push_ok) begin
            addr_mem[wr_ptr] <= q.push_addr;
            id_mem[wr_ptr]   <= q.push_id;
        end
    end

endmodule

// File: fetcher/fetch_sequencer.sv
// Drives cache reads, memory refills and responses from the two queue heads
// Only one miss is served at a time; an ID change clears both queues in the same cycle

module fetch_sequencer import icache_fetch_pkg::*; (
    input  logic                aclk,
    input  logic                aresetn,
    // Request and miss queues
    fetch_queue_if.drain        req,
    fetch_queue_if.fill_drain   miss,
    // Core controller request side
    input  logic [ID_W-1:0]     ctrl_arid,
    output logic                ctrl_arready,
    // Core controller response side
    output logic                ctrl_rvalid,
    input  logic                ctrl_rready,
    output logic [ID_W-1:0]     ctrl_rid,
    output logic [ILEN-1:0]     ctrl_rdata,
    // Memory controller read request
    output logic                memctrl_arvalid,
    input  logic                memctrl_arready,
    output logic [ADDR_W-1:0]   memctrl_araddr,
    output logic [ID_W-1:0]     memctrl_arid,
    // Cache line read port
    input  logic                cache_writing,
    output logic                cache_ren,
    output logic [ADDR_W-1:0]   cache_raddr,
    input  logic [ILEN-1:0]     cache_rdata,
    input  logic                cache_hit,
    input  logic                cache_miss
);

    logic [SEQ_W-1:0]  state;

    // Reboot detection
    logic [ID_W-1:0]   prev_id;
    logic              reboot;

    // Cache read selection
    logic              sel_miss;
    logic [ID_W-1:0]   sel_id;
    logic              rd_ok;
    logic [ADDR_W-1:0] rd_addr;
    logic [ID_W-1:0]   rd_id;

    // Miss handling
    logic              miss_start;

    // Response hold under back-pressure
    logic              rvalid_r;
    logic [ILEN-1:0]   rdata_hold;

    ////////////////////////////////////////
    // Reboot on ID change
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            prev_id <= '0;
        end else begin
            prev_id <= ctrl_arid;
        end
    end

    // A new ID means the core jumped, queued work is stale
    assign reboot = (ctrl_arid != prev_id);

    assign req.clear  = reboot;
    assign miss.clear = reboot;

    // Accept only out of reset, with room and no jump in progress
    assign ctrl_arready = aresetn & ~req.full & ~reboot;

    ////////////////////////////////////////
    // Cache read path
    ////////////////////////////////////////

    // Missed entries go before newer requests
    assign sel_miss    = ~miss.empty;
    assign cache_raddr = sel_miss ? miss.head_addr : req.head_addr;
    assign sel_id      = sel_miss ? miss.head_id : req.head_id;

    // No read while stalled, on a jump, or while a miss is coming back;
    // a read behind a miss would overtake it
    assign rd_ok = ctrl_rready & ~reboot & ~cache_miss & ~miss.full;

    assign cache_ren = (state != SEQ_LOAD) & (~miss.empty | ~req.empty) & rd_ok;

    // Pull the queue whose head was read
    assign req.pull  = cache_ren & ~sel_miss;
    assign miss.pull = cache_ren & sel_miss;

    // Address and ID of the read in flight, for the miss push and the response
    always_ff @(posedge aclk) begin
        if (cache_ren) begin
            rd_addr <= cache_raddr;
            rd_id   <= sel_id;
        end
    end

    // Missed entry goes back to the miss queue, clear wins on a jump
    assign miss.push      = cache_miss;
    assign miss.push_addr = rd_addr;
    assign miss.push_id   = rd_id;

    ////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////

    // A miss is only seen outside LOAD, reads stop there
    assign miss_start = (state != SEQ_LOAD) & ~reboot & cache_miss;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state           <= SEQ_IDLE;
            memctrl_arvalid <= 1'b0;
        end else begin
            case (state)
                SEQ_LOAD: begin
                    // Request held until memory takes it
                    if (memctrl_arvalid && memctrl_arready) begin
                        memctrl_arvalid <= 1'b0;
                    end
                    // Line written, re-read the missed entries
                    // A reboot here already cleared them, MISSED then moves on
                    if (cache_writing) begin
                        state <= SEQ_MISSED;
                    end
                end
                default: begin
                    if (reboot) begin
                        state <= SEQ_IDLE;
                    end else if (miss_start) begin
                        memctrl_arvalid <= 1'b1;
                        state           <= SEQ_LOAD;
                    end else if (!miss.empty) begin
                        state <= SEQ_MISSED;
                    end else if (!req.empty) begin
                        state <= SEQ_SERVE;
                    end else begin
                        state <= SEQ_IDLE;
                    end
                end
            endcase
        end
    end

    // Memory request payload, stable while memctrl_arvalid is high
    always_ff @(posedge aclk) begin
        if (miss_start) begin
            memctrl_araddr <= rd_addr;
            memctrl_arid   <= rd_id;
        end
    end

    ////////////////////////////////////////
    // Response path
    ////////////////////////////////////////

    // Hit not taken gets one extra cycle, no more
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rvalid_r <= 1'b0;
        end else begin
            rvalid_r <= cache_hit & ~reboot & ~ctrl_rready;
        end
    end

    // Cache data is only valid in the hit cycle
    always_ff @(posedge aclk) begin
        if (cache_hit) begin
            rdata_hold <= cache_rdata;
        end
    end

    // Old-ID data is dropped on a jump
    assign ctrl_rvalid = (cache_hit | rvalid_r) & ~reboot;
    assign ctrl_rdata  = rvalid_r ? rdata_hold : cache_rdata;
    // rd_id cannot move in the held cycle, reads stop while ctrl_rready is low
    assign ctrl_rid    = rd_id;

endmodule

// File: verilog/icache_fetcher.sv
// Instruction cache fetch front end with plain ports
// Cache answers hit or miss one cycle after cache_ren; cache_writing is a one-cycle pulse

module icache_fetcher import icache_fetch_pkg::*; (
    input  logic              aclk,
    input  logic              aresetn,
    // Core controller read request
    input  logic              ctrl_arvalid,
    output logic              ctrl_arready,
    input  logic [ADDR_W-1:0] ctrl_araddr,
    input  logic [ID_W-1:0]   ctrl_arid,
    // Core controller read response
    output logic              ctrl_rvalid,
    input  logic              ctrl_rready,
    output logic [ID_W-1:0]   ctrl_rid,
    output logic [ILEN-1:0]   ctrl_rdata,
    // Memory controller read request
    output logic              memctrl_arvalid,
    input  logic              memctrl_arready,
    output logic [ADDR_W-1:0] memctrl_araddr,
    output logic [ID_W-1:0]   memctrl_arid,
    // Cache line read port
    input  logic              cache_writing,
    output logic              cache_ren,
    output logic [ADDR_W-1:0] cache_raddr,
    input  logic [ILEN-1:0]   cache_rdata,
    input  logic              cache_hit,
    input  logic              cache_miss
);

    fetch_queue_if req_if ();
    fetch_queue_if miss_if ();

    ////////////////////////////////////////
    // Request queue
    ////////////////////////////////////////

    // Push follows arvalid, the queue drops it when full and clear wins on a jump
    assign req_if.push      = ctrl_arvalid;
    assign req_if.push_addr = ctrl_araddr;
    assign req_if.push_id   = ctrl_arid;

    fetch_queue #(
        .depth (REQ_DEPTH)
    ) u_req_queue (
        .aclk    (aclk),
        .aresetn (aresetn),
        .q       (req_if.queue)
    );

    // Missed entries waiting for a refill
    fetch_queue #(
        .depth (MISS_DEPTH)
    ) u_miss_queue (
        .aclk    (aclk),
        .aresetn (aresetn),
        .q       (miss_if.queue)
    );

    ////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////

    fetch_sequencer u_sequencer (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .req             (req_if.drain),
        .miss            (miss_if.fill_drain),
        .ctrl_arid       (ctrl_arid),
        .ctrl_arready    (ctrl_arready),
        .ctrl_rvalid     (ctrl_rvalid),
        .ctrl_rready     (ctrl_rready),
        .ctrl_rid        (ctrl_rid),
        .ctrl_rdata      (ctrl_rdata),
        .memctrl_arvalid (memctrl_arvalid),
        .memctrl_arready (memctrl_arready),
        .memctrl_araddr  (memctrl_araddr),
        .memctrl_arid    (memctrl_arid),
        .cache_writing   (cache_writing),
        .cache_ren       (cache_ren),
        .cache_raddr     (cache_raddr),
        .cache_rdata     (cache_rdata),
        .cache_hit       (cache_hit),
        .cache_miss      (cache_miss)
    );

endmodule

// File: tests/icache_fetcher_props.sv
// Handshake and reset rules, bound into icache_fetcher
// Assumes cache_hit is held low by the environment while in reset

module icache_fetcher_props import icache_fetch_pkg::*; (
    input logic              aclk,
    input logic              aresetn,
    input logic [ID_W-1:0]   ctrl_arid,
    input logic              ctrl_arready,
    input logic              ctrl_rvalid,
    input logic              ctrl_rready,
    input logic [ID_W-1:0]   ctrl_rid,
    input logic [ILEN-1:0]   ctrl_rdata,
    input logic              memctrl_arvalid,
    input logic              memctrl_arready,
    input logic              cache_ren
);

    // Nothing moves while in reset
    reset_quiet: assert property (@(posedge aclk)
        !aresetn |-> (!ctrl_arready && !ctrl_rvalid && !memctrl_arvalid && !cache_ren))
        else $error("control output active during reset");

    // Memory request waits for its handshake
    mem_req_held: assert property (@(posedge aclk) disable iff (!aresetn)
        memctrl_arvalid && !memctrl_arready |=> memctrl_arvalid)
        else $error("memctrl_arvalid dropped before memctrl_arready");

    // Held response is unchanged unless a jump drops it
    rsp_held: assert property (@(posedge aclk) disable iff (!aresetn)
        ctrl_rvalid && !ctrl_rready |=> (ctrl_arid != $past(ctrl_arid)) ||
        (ctrl_rvalid && $stable(ctrl_rdata) && $stable(ctrl_rid)))
        else $error("response changed in the held cycle");

endmodule

bind icache_fetcher icache_fetcher_props u_props (
    .aclk            (aclk),
    .aresetn         (aresetn),
    .ctrl_arid       (ctrl_arid),
    .ctrl_arready    (ctrl_arready),
    .ctrl_rvalid     (ctrl_rvalid),
    .ctrl_rready     (ctrl_rready),
    .ctrl_rid        (ctrl_rid),
    .ctrl_rdata      (ctrl_rdata),
    .memctrl_arvalid (memctrl_arvalid),
    .memctrl_arready (memctrl_arready),
    .cache_ren       (cache_ren)
);

// File: tests/tb_icache_fetcher.sv
// Testbench for icache_fetcher with cache and memory models, driven from tests/fetch_vectors.txt
// Inputs change on the falling edge; outputs are sampled 1 time unit later

module tb_icache_fetcher import icache_fetch_pkg::*; ();

    localparam int PERIOD       = 40;
    localparam int NUM_VECS     = 40;
    localparam int TEST_LEN     = 8;
    localparam int REFILL_DELAY = 3;
    localparam logic [ILEN-1:0] DATA_KEY = 32'h5a5a_a5a5;

    logic              aclk = 1'b0;
    logic              aresetn;
    logic              ctrl_arvalid;
    logic              ctrl_arready;
    logic [ADDR_W-1:0] ctrl_araddr;
    logic [ID_W-1:0]   ctrl_arid;
    logic              ctrl_rvalid;
    logic              ctrl_rready;
    logic [ID_W-1:0]   ctrl_rid;
    logic [ILEN-1:0]   ctrl_rdata;
    logic              memctrl_arvalid;
    logic              memctrl_arready;
    logic [ADDR_W-1:0] memctrl_araddr;
    logic [ID_W-1:0]   memctrl_arid;
    logic              cache_writing;
    logic              cache_ren;
    logic [ADDR_W-1:0] cache_raddr;
    logic [ILEN-1:0]   cache_rdata;
    logic              cache_hit;
    logic              cache_miss;

    // Vector word: address, ID, cached flag, ready pattern
    logic [63:0]       vecs [NUM_VECS];
    // Scoreboard of accepted requests, oldest first
    logic [ADDR_W-1:0] sb_addr [$];
    logic [ID_W-1:0]   sb_id [$];
    logic [15:0]       sb_ready [$];
    // Uncached requests still owed a memory read
    logic [ADDR_W-1:0] miss_addr [$];
    logic [ID_W-1:0]   miss_id [$];
    // Cache model state, one entry per 16-byte line
    bit                present [logic [27:0]];
    logic              pend_ren;
    logic [ADDR_W-1:0] pend_addr;
    int                refill_cnt;
    logic [27:0]       refill_line;
    // Response hold tracking
    logic              hold_pending;
    logic [ILEN-1:0]   hold_data;
    logic [ID_W-1:0]   hold_id;
    // ID changed in the current cycle
    logic              id_jump;
    logic [3:0]        rcyc;
    logic [31:0]       rnd;
    integer            seed;
    int                err_count;
    int                req_count;
    int                rsp_count;
    int                mem_reads;

    icache_fetcher u_dut (.*);

    always #(PERIOD / 2) aclk = ~aclk;

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        err_count++;
        $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    endtask

    task automatic report_failure(input string what);
        err_count++;
        $display("error at %0t: %s", $time, what);
    endtask

    ////////////////////////////////////////
    // Cache, memory and response models
    ////////////////////////////////////////

    always @(negedge aclk) begin
        // Cache answers the read seen one cycle earlier
        cache_hit   = pend_ren && present.exists(pend_addr[31:4]);
        cache_miss  = pend_ren && !present.exists(pend_addr[31:4]);
        cache_rdata = cache_hit ? (pend_addr ^ DATA_KEY) : '0;
        rnd = $random(seed);
        memctrl_arready = rnd[0];
        // Line write pulse once the refill delay runs out
        cache_writing = 1'b0;
        if (refill_cnt > 0) begin
            refill_cnt--;
            if (refill_cnt == 0) begin
                present[refill_line] = 1'b1;
                cache_writing = 1'b1;
            end
        end
        // Ready pattern of the oldest outstanding request
        ctrl_rready = (sb_ready.size() == 0) ? 1'b1 : sb_ready[0][rcyc];
        rcyc = rcyc + 4'd1;
        #1;
        pend_ren  = cache_ren;
        pend_addr = cache_raddr;
        if (memctrl_arvalid && memctrl_arready) begin
            mem_reads++;
            if (miss_addr.size() == 0) begin
                report_failure("memory read issued with no miss outstanding");
            end else begin
                if (memctrl_araddr !== miss_addr[0])
                    report_value("memctrl_araddr", memctrl_araddr, miss_addr[0]);
                if (memctrl_arid !== miss_id[0])
                    report_value("memctrl_arid", 32'(memctrl_arid), 32'(miss_id[0]));
                void'(miss_addr.pop_front());
                void'(miss_id.pop_front());
            end
            refill_line = memctrl_araddr[31:4];
            refill_cnt  = REFILL_DELAY;
        end
        if (id_jump) begin
            // Jump cycle drops every old-ID response, queued request and unissued miss
            id_jump      = 1'b0;
            hold_pending = 1'b0;
            if (ctrl_rvalid !== 1'b0)
                report_value("ctrl_rvalid", 32'(ctrl_rvalid), 32'd0);
            sb_addr.delete();
            sb_id.delete();
            sb_ready.delete();
            // A memory read already raised still completes
            while (miss_addr.size() > ((memctrl_arvalid && !memctrl_arready) ? 1 : 0)) begin
                void'(miss_addr.pop_back());
                void'(miss_id.pop_back());
            end
        end else begin
            // Held cycle keeps valid, data and ID
            if (hold_pending) begin
                if (ctrl_rvalid !== 1'b1) begin
                    report_failure("ctrl_rvalid dropped in the held cycle");
                end else begin
                    if (ctrl_rdata !== hold_data)
                        report_value("ctrl_rdata", ctrl_rdata, hold_data);
                    if (ctrl_rid !== hold_id)
                        report_value("ctrl_rid", 32'(ctrl_rid), 32'(hold_id));
                end
            end
            hold_pending = ctrl_rvalid && !ctrl_rready;
            hold_data    = ctrl_rdata;
            hold_id      = ctrl_rid;
            if (ctrl_rvalid && ctrl_rready) begin
                rsp_count++;
                if (sb_addr.size() == 0) begin
                    report_failure("response arrived with no request outstanding");
                end else begin
                    if (ctrl_rdata !== (sb_addr[0] ^ DATA_KEY))
                        report_value("ctrl_rdata", ctrl_rdata, sb_addr[0] ^ DATA_KEY);
                    if (ctrl_rid !== sb_id[0])
                        report_value("ctrl_rid", 32'(ctrl_rid), 32'(sb_id[0]));
                    void'(sb_addr.pop_front());
                    void'(sb_id.pop_front());
                    void'(sb_ready.pop_front());
                end
            end
        end
    end

    ////////////////////////////////////////
    // Request driver
    ////////////////////////////////////////

    // Stop requesting and wait until every response is back
    task automatic wait_drained();
        @(negedge aclk);
        ctrl_arvalid = 1'b0;
        #2;
        while (sb_addr.size() != 0) begin
            @(negedge aclk);
            #2;
        end
    endtask

    // A new ID is a jump, no request may be taken in that cycle
    task automatic change_id(input logic [ID_W-1:0] id);
        @(negedge aclk);
        ctrl_arvalid = 1'b0;
        ctrl_arid    = id;
        id_jump      = 1'b1;
        #1;
        if (ctrl_arready !== 1'b0)
            report_failure("ctrl_arready high in the cycle ctrl_arid changed");
    endtask

    task automatic issue_request(input int v);
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        logic              took;
        addr = vecs[v][63:32];
        id   = vecs[v][31:24];
        if (id != ctrl_arid) begin
            change_id(id);
        end
        do begin
            @(negedge aclk);
            ctrl_arvalid = 1'b1;
            ctrl_araddr  = addr;
            #1;
            took = ctrl_arready;
        end while (!took);
        req_count++;
        sb_addr.push_back(addr);
        sb_id.push_back(id);
        sb_ready.push_back(vecs[v][15:0]);
        if (!vecs[v][16]) begin
            miss_addr.push_back(addr);
            miss_id.push_back(id);
        end
    endtask

    function automatic string test_name(input int t);
        case (t)
            0: return "all hits";
            1: return "misses and refills";
            2: return "back-pressure";
            3: return "mixed misses and back-pressure";
            default: return "ID changes";
        endcase
    endfunction

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        int err0;
        int rsp0;
        int mem0;
        aresetn = 1'b0;
        ctrl_arvalid = 1'b0;
        ctrl_araddr = '0;
        ctrl_arid = '0;
        ctrl_rready = 1'b1;
        memctrl_arready = 1'b0;
        cache_writing = 1'b0;
        cache_rdata = '0;
        cache_hit = 1'b0;
        cache_miss = 1'b0;
        pend_ren = 1'b0;
        pend_addr = '0;
        refill_cnt = 0;
        refill_line = '0;
        hold_pending = 1'b0;
        hold_data = '0;
        hold_id = '0;
        id_jump = 1'b0;
        rcyc = '0;
        seed = 32'hb60253c1;
        err_count = 0;
        req_count = 0;
        rsp_count = 0;
        mem_reads = 0;
        $readmemh("tests/fetch_vectors.txt", vecs);
        for (int i = 0; i < NUM_VECS; i++) begin
            if (vecs[i][16])
                present[vecs[i][63:36]] = 1'b1;
        end
        repeat (5) @(negedge aclk);
        aresetn = 1'b1;
        // Idle outputs before the first request
        @(negedge aclk);
        #2;
        if (ctrl_arready !== 1'b1) report_value("ctrl_arready", 32'(ctrl_arready), 32'd1);
        if (ctrl_rvalid !== 1'b0) report_value("ctrl_rvalid", 32'(ctrl_rvalid), 32'd0);
        if (memctrl_arvalid !== 1'b0)
            report_value("memctrl_arvalid", 32'(memctrl_arvalid), 32'd0);
        if (cache_ren !== 1'b0) report_value("cache_ren", 32'(cache_ren), 32'd0);
        for (int t = 0; t < NUM_VECS / TEST_LEN; t++) begin
            err0 = err_count;
            rsp0 = rsp_count;
            mem0 = mem_reads;
            for (int v = t * TEST_LEN; v < (t + 1) * TEST_LEN; v++)
                issue_request(v);
            wait_drained();
            if (miss_addr.size() != 0)
                report_failure("uncached request finished without a memory read");
            $display("test %0d (%s): %0d responses, %0d memory reads, %0d errors",
                     t + 1, test_name(t), rsp_count - rsp0, mem_reads - mem0,
                     err_count - err0);
        end
        $display("requests %0d, responses %0d, memory reads %0d, errors %0d",
                 req_count, rsp_count, mem_reads, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Bound on the whole run, generous per vector
    initial begin
        repeat (NUM_VECS * 40 + 200) @(posedge aclk);
        $display("Watchdog expired, the DUT stopped answering requests");
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: tests/fetch_vectors.txt
// One 64-bit word per request: address[63:32] ID[31:24] cached flag[23:16] ready pattern[15:0]
// Eight lines per test; ready patterns never hold two zeros in a row
000010001101ffff
000010141101ffff
000010281101ffff
0000103c1101ffff
000010401101ffff
000010541101ffff
000010681101ffff
0000107c1101ffff
000020001100ffff
000020101101ffff
000020201100ffff
000020301101ffff
000020401101ffff
000020501100ffff
000020601101ffff
000020701100ffff
000030001101aaaa
000030101101db6d
000030201101ffff
0000303c11017777
000030401101bdbd
0000305011015555
000030641101aaaa
000030781101db6d
000040001100aaaa
000040101101ffff
000040241100db6d
000040301101bdbd
0000404811007777
000040501101aaaa
000040601100ffff
0000407c11015555
000050002201ffff
000050102200ffff
000050202201aaaa
000050303301ffff
000050403300db6d
000050504401ffff
000050604400ffff
000050744401aaaa

// File: project.f
common/icache_fetch_pkg.sv
common/fetch_queue_if.sv
fetcher/fetch_queue.sv
fetcher/fetch_sequencer.sv
verilog/icache_fetcher.sv
tests/icache_fetcher_props.sv
tests/tb_icache_fetcher.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_icache_fetcher
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# Build, run, then judge the run from its log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
